//--- include/window_params.svh
// build-time sizes and register map of the window loader
// include wherever a width, the kernel size or a register address is needed
`ifndef WINDOW_PARAMS_SVH
`define WINDOW_PARAMS_SVH

// input channels handled per pass
`define WIN_TN 4

// square kernel, rows and columns
`define WIN_K 5

// element widths
`define WIN_FEAT_W 8
`define WIN_WGT_W 8

// host register map
`define WIN_REG_CTRL 0
`define WIN_REG_STATUS 1

`endif

//--- hdl/window_pkg.sv
// shared types of the window loader
// modules refer to these by scoped name, widths come from the params header
`include "window_params.svh"

package window_pkg;

    // one feature element
    typedef logic [`WIN_FEAT_W-1:0] feat_t;

    // one row of all channels, channel-major then column
    typedef logic [`WIN_TN*`WIN_K*`WIN_FEAT_W-1:0] row_t;

    // full kernel window, first row in the top slot
    typedef logic [`WIN_K*`WIN_TN*`WIN_K*`WIN_FEAT_W-1:0] window_t;

    // flat weights for all channels of one kernel
    typedef logic [`WIN_TN*`WIN_K*`WIN_K*`WIN_WGT_W-1:0] weight_vec_t;

    // row slot inside one bank
    typedef logic [2:0] row_idx_t;

    // host register bus
    typedef logic [0:0] reg_addr_t;
    typedef logic [7:0] reg_data_t;

    // vertical register sequencer
    typedef enum logic [1:0] {
        idle,
        fill,
        done
    } shift_state_t;

endpackage

//--- hdl/row_bus_if.sv
// row enables and row data between the ping-pong bank and the vertical register
// the shifter requests rows, the bank answers one cycle after each enable
interface row_bus_if;

    // read requests, one per bank
    logic               row_en_0;
    logic               row_en_1;

    // returned rows
    window_pkg::row_t   row_0;
    window_pkg::row_t   row_1;

    modport bank (
        input  row_en_0,
        input  row_en_1,
        output row_0,
        output row_1
    );

    modport shifter (
        output row_en_0,
        output row_en_1,
        input  row_0,
        input  row_1
    );

endinterface

//--- hdl/window_ctrl_regs.sv
// host register block: start pulse, bank select and sticky done status
// writes land on the clock edge, reads are combinational
`include "window_params.svh"

module window_ctrl_regs (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  cfg_wr,
    input  window_pkg::reg_addr_t cfg_addr,
    input  window_pkg::reg_data_t cfg_wdata,
    output window_pkg::reg_data_t cfg_rdata,
    input  logic                  shift_done,
    input  logic                  busy,
    output logic                  start_pulse,
    output logic                  bank_sel
);

    logic ctrl_wr;
    logic busy_any;
    logic start_ok;
    logic done_q;

    assign ctrl_wr = cfg_wr && (cfg_addr == window_pkg::reg_addr_t'(`WIN_REG_CTRL));

    // a pulse in flight counts as busy, the shifter sees it one cycle later
    assign busy_any = busy | start_pulse;
    assign start_ok = ctrl_wr && cfg_wdata[0] && !busy_any;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            start_pulse <= 1'b0;
            bank_sel    <= 1'b0;
            done_q      <= 1'b0;
        end else begin
            // start bit is self-clearing, only the pulse survives
            start_pulse <= start_ok;
            if (ctrl_wr) begin
                bank_sel <= cfg_wdata[1];
            end
            // sticky until the next accepted start
            if (start_ok) begin
                done_q <= 1'b0;
            end else if (shift_done) begin
                done_q <= 1'b1;
            end
        end
    end

    always_comb begin
        cfg_rdata = '0;
        if (cfg_addr == window_pkg::reg_addr_t'(`WIN_REG_STATUS)) begin
            cfg_rdata[0] = done_q;
            cfg_rdata[1] = busy_any;
            cfg_rdata[2] = bank_sel;
        end else begin
            // control readback, start always reads 0
            cfg_rdata[1] = bank_sel;
        end
    end

endmodule

//--- hdl/row_bank.sv
// two five-row ping-pong feature banks
// host writes rows by index, the shifter reads them out in order under the row enables
`include "window_params.svh"

module row_bank (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 row_wr,
    input  logic                 row_wr_bank,
    input  window_pkg::row_idx_t row_wr_idx,
    input  window_pkg::row_t     row_wr_data,
    row_bus_if.bank              rows
);

    localparam int ROWS = `WIN_K;

    window_pkg::row_t     mem_0 [ROWS];
    window_pkg::row_t     mem_1 [ROWS];

    // read pointers, one per bank
    window_pkg::row_idx_t rd_idx_0;
    window_pkg::row_idx_t rd_idx_1;

    // host writes, either bank may be written while the other is read
    always_ff @(posedge clk) begin
        if (row_wr && !row_wr_bank) begin
            mem_0[row_wr_idx] <= row_wr_data;
        end
        if (row_wr && row_wr_bank) begin
            mem_1[row_wr_idx] <= row_wr_data;
        end
    end

    // registered read, data shows up one cycle after the enable
    always_ff @(posedge clk) begin
        if (rows.row_en_0) begin
            rows.row_0 <= mem_0[rd_idx_0];
        end
        if (rows.row_en_1) begin
            rows.row_1 <= mem_1[rd_idx_1];
        end
    end

    // pointers advance per enable cycle and restart once the enable drops
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_idx_0 <= '0;
            rd_idx_1 <= '0;
        end else begin
            if (!rows.row_en_0) begin
                rd_idx_0 <= '0;
            end else if (rd_idx_0 == window_pkg::row_idx_t'(ROWS - 1)) begin
                rd_idx_0 <= '0;
            end else begin
                rd_idx_0 <= rd_idx_0 + 1'b1;
            end

            if (!rows.row_en_1) begin
                rd_idx_1 <= '0;
            end else if (rd_idx_1 == window_pkg::row_idx_t'(ROWS - 1)) begin
                rd_idx_1 <= '0;
            end else begin
                rd_idx_1 <= rd_idx_1 + 1'b1;
            end
        end
    end

endmodule

//--- hdl/vertical_reg.sv
// row enable sequencer and five-row window shift register
// one start pulse fetches WIN_K rows from the selected bank and ends with shift_done
`include "window_params.svh"

module vertical_reg (
    input  logic                clk,
    input  logic                rst,
    input  logic                start,
    input  logic                bank_sel,
    row_bus_if.shifter          rows,
    output window_pkg::window_t window,
    output logic                busy,
    output logic                shift_done
);

    localparam int ROW_W    = $bits(window_pkg::row_t);
    localparam int RUN_LAST = `WIN_K - 1;

    window_pkg::shift_state_t state;
    window_pkg::row_idx_t     run_cnt;

    // enables delayed to line up with the bank's registered read data
    logic sel_0_d;
    logic sel_1_d;
    logic last_shift;
    logic done_flag;

    // enable sequencer
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state         <= window_pkg::idle;
            run_cnt       <= '0;
            rows.row_en_0 <= 1'b0;
            rows.row_en_1 <= 1'b0;
        end else begin
            case (state)
                window_pkg::idle: begin
                    if (start) begin
                        rows.row_en_0 <= !bank_sel;
                        rows.row_en_1 <= bank_sel;
                        run_cnt       <= '0;
                        state         <= window_pkg::fill;
                    end
                end
                window_pkg::fill: begin
                    // enable stays up for exactly WIN_K cycles
                    if (run_cnt == window_pkg::row_idx_t'(RUN_LAST)) begin
                        rows.row_en_0 <= 1'b0;
                        rows.row_en_1 <= 1'b0;
                        state         <= window_pkg::done;
                    end else begin
                        run_cnt <= run_cnt + 1'b1;
                    end
                end
                window_pkg::done: begin
                    // hold off new starts until the done pulse is out
                    if (shift_done) begin
                        state <= window_pkg::idle;
                    end
                end
                default: begin
                    state <= window_pkg::idle;
                end
            endcase
        end
    end

    assign busy = (state != window_pkg::idle);

    // the last row is in flight once the enable has dropped
    assign last_shift = (sel_0_d | sel_1_d) & ~(rows.row_en_0 | rows.row_en_1);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sel_0_d    <= 1'b0;
            sel_1_d    <= 1'b0;
            done_flag  <= 1'b0;
            shift_done <= 1'b0;
        end else begin
            sel_0_d    <= rows.row_en_0;
            sel_1_d    <= rows.row_en_1;
            // two stages, window is settled well before the pulse
            done_flag  <= last_shift;
            shift_done <= done_flag;
        end
    end

    // new row enters at the bottom, first row ends up in the top slot
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            window <= '0;
        end else if (sel_0_d) begin
            window <= {window[ROW_W*(`WIN_K-1)-1:0], rows.row_0};
        end else if (sel_1_d) begin
            window <= {window[ROW_W*(`WIN_K-1)-1:0], rows.row_1};
        end
    end

endmodule

//--- hdl/operand_reorder.sv
// captures the window and weights and reorders them for the MAC array
// out_valid pulses one cycle after capture, permutations are fixed for Tn=4, K=5
`include "window_params.svh"

module operand_reorder (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    capture,
    input  window_pkg::window_t     window,
    input  window_pkg::weight_vec_t weight_in,
    output window_pkg::window_t     window_out,
    output window_pkg::weight_vec_t weight_out,
    output logic                    out_valid
);

    localparam int N   = `WIN_TN * `WIN_K * `WIN_K;
    localparam int KK  = `WIN_K * `WIN_K;
    localparam int CK  = `WIN_TN * `WIN_K;
    localparam int FW  = `WIN_FEAT_W;
    localparam int WW  = `WIN_WGT_W;

    window_pkg::window_t     win_perm;
    window_pkg::weight_vec_t wgt_perm;

    for (genvar i = 0; i < N; i++) begin : g_perm
        // feature: kernel elements of each column become contiguous
        localparam int FSRC = (i % KK) / `WIN_K + `WIN_K * (i / KK) + CK * (i % `WIN_K);
        // weight: channel block, then row, then column
        localparam int WSRC = KK * ((i / `WIN_K) % `WIN_TN) + `WIN_K * (i % `WIN_K) + i / CK;

        window_pkg::feat_t feat;

        assign feat                  = window[FSRC*FW +: FW];
        assign win_perm[i*FW +: FW]  = feat;
        assign wgt_perm[i*WW +: WW]  = weight_in[WSRC*WW +: WW];
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            window_out <= '0;
            weight_out <= '0;
            out_valid  <= 1'b0;
        end else begin
            out_valid <= capture;
            // weights are sampled together with the window
            if (capture) begin
                window_out <= win_perm;
                weight_out <= wgt_perm;
            end
        end
    end

endmodule

//--- hdl/window_loader_top.sv
// window loading stage: host registers, ping-pong row banks, window shifter, reorder
// host loads a bank, selects it, pulses start and collects the reordered operands
module window_loader_top (
    input  logic                    clk,
    input  logic                    rst,

    // configuration registers
    input  logic                    cfg_wr,
    input  window_pkg::reg_addr_t   cfg_addr,
    input  window_pkg::reg_data_t   cfg_wdata,
    output window_pkg::reg_data_t   cfg_rdata,

    // row write port
    input  logic                    row_wr,
    input  logic                    row_wr_bank,
    input  window_pkg::row_idx_t    row_wr_idx,
    input  window_pkg::row_t        row_wr_data,

    // weights, sampled at capture
    input  window_pkg::weight_vec_t weight_in,

    // operands to the MAC array
    output window_pkg::window_t     window_out,
    output window_pkg::weight_vec_t weight_out,
    output logic                    out_valid
);

    logic                start_pulse;
    logic                bank_sel;
    logic                busy;
    logic                shift_done;
    window_pkg::window_t window;

    row_bus_if u_row_bus ();

    window_ctrl_regs u_window_ctrl_regs (
        .clk         (clk),
        .rst         (rst),
        .cfg_wr      (cfg_wr),
        .cfg_addr    (cfg_addr),
        .cfg_wdata   (cfg_wdata),
        .cfg_rdata   (cfg_rdata),
        .shift_done  (shift_done),
        .busy        (busy),
        .start_pulse (start_pulse),
        .bank_sel    (bank_sel)
    );

    row_bank u_row_bank (
        .clk         (clk),
        .rst         (rst),
        .row_wr      (row_wr),
        .row_wr_bank (row_wr_bank),
        .row_wr_idx  (row_wr_idx),
        .row_wr_data (row_wr_data),
        .rows        (u_row_bus.bank)
    );

    vertical_reg u_vertical_reg (
        .clk        (clk),
        .rst        (rst),
        .start      (start_pulse),
        .bank_sel   (bank_sel),
        .rows       (u_row_bus.shifter),
        .window     (window),
        .busy       (busy),
        .shift_done (shift_done)
    );

    // capture as soon as the window is complete
    operand_reorder u_operand_reorder (
        .clk        (clk),
        .rst        (rst),
        .capture    (shift_done),
        .window     (window),
        .weight_in  (weight_in),
        .window_out (window_out),
        .weight_out (weight_out),
        .out_valid  (out_valid)
    );

endmodule

//--- sim/window_loader_props.sv
// concurrent checks on the row enables and on the done and valid pulses
// bound into vertical_reg and operand_reorder at the end of this file
`include "window_params.svh"

module window_loader_props #(
    parameter bit CHECK_VALID = 1'b1
) (
    input logic clk,
    input logic rst,
    input logic row_en_0,
    input logic row_en_1,
    input logic shift_done,
    input logic out_valid
);
    timeunit 1ns;
    timeprecision 100ps;

    if (CHECK_VALID) begin : g_valid
        a_valid_after_done: assert property (@(posedge clk) disable iff (rst)
            shift_done |=> out_valid)
            else $error("out_valid missing one cycle after shift_done");

        a_valid_only_after_done: assert property (@(posedge clk) disable iff (rst)
            out_valid |-> $past(shift_done))
            else $error("out_valid without shift_done one cycle before");
    end else begin : g_rows
        logic       row_en;
        // cycles the current enable run has lasted
        logic [3:0] run_len;

        assign row_en = row_en_0 | row_en_1;

        always_ff @(posedge clk or posedge rst) begin
            if (rst) begin
                run_len <= '0;
            end else if (row_en) begin
                run_len <= run_len + 1'b1;
            end else begin
                run_len <= '0;
            end
        end

        a_one_bank: assert property (@(posedge clk) disable iff (rst) !(row_en_0 && row_en_1))
            else $error("both row enables are high in the same cycle");

        a_run_max: assert property (@(posedge clk) disable iff (rst)
            row_en |-> run_len < 4'(`WIN_K))
            else $error("row enable run is longer than the kernel size");

        // run has just ended, so the counter holds its length
        a_run_len: assert property (@(posedge clk) disable iff (rst)
            (!row_en && run_len != 0) |-> run_len == 4'(`WIN_K))
            else $error("row enable run is shorter than the kernel size");

        // done is staged twice behind the last row
        a_done_after_run: assert property (@(posedge clk) disable iff (rst)
            $fell(row_en) |-> ##2 shift_done)
            else $error("shift_done not two cycles after the end of the row enable run");
    end

endmodule

bind vertical_reg window_loader_props #(.CHECK_VALID(1'b0)) u_shift_props (
    .clk        (clk),
    .rst        (rst),
    .row_en_0   (rows.row_en_0),
    .row_en_1   (rows.row_en_1),
    .shift_done (shift_done),
    .out_valid  (1'b0)
);

bind operand_reorder window_loader_props u_reorder_props (
    .clk        (clk),
    .rst        (rst),
    .row_en_0   (1'b0),
    .row_en_1   (1'b0),
    .shift_done (capture),
    .out_valid  (out_valid)
);

//--- sim/window_loader_tb.sv
// testbench of the window loader that fills both banks, runs the shifter and checks operands
// every out_valid is compared with a reference model built from the rows written here
`include "window_params.svh"

module window_loader_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int K       = `WIN_K;
    localparam int TN      = `WIN_TN;
    localparam int FW      = `WIN_FEAT_W;
    localparam int WW      = `WIN_WGT_W;
    localparam int ROW_W   = $bits(window_pkg::row_t);
    localparam int CHK_W   = $bits(window_pkg::window_t);
    localparam int TIMEOUT = 50;
    localparam window_pkg::reg_addr_t CTRL   = window_pkg::reg_addr_t'(`WIN_REG_CTRL);
    localparam window_pkg::reg_addr_t STATUS = window_pkg::reg_addr_t'(`WIN_REG_STATUS);

    logic                    clk;
    logic                    rst;
    logic                    cfg_wr;
    window_pkg::reg_addr_t   cfg_addr;
    window_pkg::reg_data_t   cfg_wdata;
    window_pkg::reg_data_t   cfg_rdata;
    logic                    row_wr;
    logic                    row_wr_bank;
    window_pkg::row_idx_t    row_wr_idx;
    window_pkg::row_t        row_wr_data;
    window_pkg::weight_vec_t weight_in;
    window_pkg::window_t     window_out;
    window_pkg::weight_vec_t weight_out;
    logic                    out_valid;

    // model of the bank contents and of the pending result
    window_pkg::row_t        bank_rows [2][K];
    window_pkg::window_t     exp_window;
    window_pkg::weight_vec_t exp_weight;
    string                   test_name = "reset";
    int                      valid_count = 0;
    int                      accepted = 0;
    integer                  seed = 27;
    window_pkg::reg_data_t   st;

    window_loader_top u_window_loader_top (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [CHK_W-1:0] expected,
                               input logic [CHK_W-1:0] actual);
        if (expected !== actual) begin
            $display("FAILED %s expected %h actual %h", name, expected, actual);
            abort_run("value mismatch");
        end
    endtask

    function automatic window_pkg::window_t rand_vec();
        window_pkg::window_t v;
        for (int w = 0; w < CHK_W / 32; w++) begin
            v[w*32 +: 32] = $random(seed);
        end
        return v;
    endfunction

    // MAC order is channel, then column, then row slot with row 0 in the top slot
    function automatic window_pkg::window_t ref_window(input int bank);
        window_pkg::window_t flat;
        window_pkg::window_t res;
        for (int r = 0; r < K; r++) begin
            flat[(K-1-r)*ROW_W +: ROW_W] = bank_rows[bank][r];
        end
        for (int ch = 0; ch < TN; ch++) begin
            for (int col = 0; col < K; col++) begin
                for (int slot = 0; slot < K; slot++) begin
                    res[((ch*K + col)*K + slot)*FW +: FW] =
                        flat[(slot*TN*K + ch*K + col)*FW +: FW];
                end
            end
        end
        return res;
    endfunction

    // weights come in as channel, row, column and leave as column, channel, row
    function automatic window_pkg::weight_vec_t ref_weights(input window_pkg::weight_vec_t w);
        window_pkg::weight_vec_t res;
        for (int col = 0; col < K; col++) begin
            for (int ch = 0; ch < TN; ch++) begin
                for (int row = 0; row < K; row++) begin
                    res[(col*TN*K + ch*K + row)*WW +: WW] = w[(ch*K*K + row*K + col)*WW +: WW];
                end
            end
        end
        return res;
    endfunction

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic cfg_write(input window_pkg::reg_addr_t addr, input window_pkg::reg_data_t data);
        cfg_wr    = 1'b1;
        cfg_addr  = addr;
        cfg_wdata = data;
        step();
        cfg_wr    = 1'b0;
    endtask

    task automatic cfg_read(input window_pkg::reg_addr_t addr, output window_pkg::reg_data_t data);
        cfg_addr = addr;
        #1;
        data = cfg_rdata;
    endtask

    task automatic load_bank(input int bank);
        for (int r = 0; r < K; r++) begin
            bank_rows[bank][r] = window_pkg::row_t'(rand_vec());
            row_wr      = 1'b1;
            row_wr_bank = bank[0];
            row_wr_idx  = window_pkg::row_idx_t'(r);
            row_wr_data = bank_rows[bank][r];
            step();
        end
        row_wr = 1'b0;
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        cfg_read(STATUS, st);
        while (st[1] && n < TIMEOUT) begin
            step();
            cfg_read(STATUS, st);
            n++;
        end
        if (st[1]) begin
            abort_run("timeout waiting for the shifter to go idle");
        end
    endtask

    task automatic start_run(input int bank, input string name);
        wait_idle();
        test_name  = name;
        weight_in  = rand_vec();
        exp_weight = ref_weights(weight_in);
        exp_window = ref_window(bank);
        cfg_write(CTRL, {6'b0, bank[0], 1'b1});
        accepted++;
    endtask

    task automatic wait_valid();
        int n;
        n = 0;
        while (valid_count < accepted && n < TIMEOUT) begin
            step();
            n++;
        end
        if (valid_count < accepted) begin
            abort_run({"timeout waiting for out_valid in ", test_name});
        end
    endtask

    // compare process sampling the registered outputs mid-cycle
    always @(negedge clk) begin
        if (!rst && out_valid) begin
            check_value({test_name, "_window"}, exp_window, window_out);
            check_value({test_name, "_weights"}, exp_weight, weight_out);
            valid_count++;
        end
    end

    initial begin
        rst = 1'b1;
        cfg_wr = 1'b0;
        cfg_addr = CTRL;
        cfg_wdata = '0;
        row_wr = 1'b0;
        row_wr_bank = 1'b0;
        row_wr_idx = '0;
        row_wr_data = '0;
        weight_in = '0;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;

        check_value("reset_valid", 0, out_valid);
        cfg_read(STATUS, st);
        check_value("reset_status", 0, st);

        load_bank(0);
        start_run(0, "bank0");
        wait_valid();
        cfg_read(STATUS, st);
        check_value("done_set", 1, st[0]);

        load_bank(1);
        start_run(1, "bank1");
        cfg_read(STATUS, st);
        check_value("done_cleared", 0, st[0]);
        check_value("bank_echo", 1, st[2]);
        wait_valid();
        check_value("bank1_differs", 1, window_out != ref_window(0));

        // bank 0 is rewritten while bank 1 is being read
        start_run(1, "bank1_again");
        load_bank(0);
        wait_valid();
        start_run(0, "bank0_rewritten");
        wait_valid();

        // second start lands while the shifter is busy and must be dropped
        start_run(0, "busy_start");
        step();
        cfg_read(STATUS, st);
        check_value("busy_flag", 1, st[1]);
        cfg_write(CTRL, 8'h01);
        wait_valid();
        wait_idle();
        repeat (4) step();
        check_value("valid_count", accepted, valid_count);

        $display("=== PASS ===");
        $finish;
    end

endmodule

//--- project.f
+incdir+include
hdl/window_pkg.sv
hdl/row_bus_if.sv
hdl/window_ctrl_regs.sv
hdl/row_bank.sv
hdl/vertical_reg.sv
hdl/operand_reorder.sv
hdl/window_loader_top.sv
sim/window_loader_props.sv
sim/window_loader_tb.sv

//--- Makefile
# Verilator build and run of the window loader testbench

SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP      = window_loader_tb
FILELIST = project.f
BUILD    = obj_dir
LOG      = sim.log
PASS     = === PASS ===

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) 2>&1 | tee $(LOG)
	grep -qF -- "$(PASS)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
